//--- hw/axi_lite_pkg.sv
// AXI4-Lite bus types
// Channel structs as seen from the slave and the internal write
// commit and read service commands
package axi_lite_pkg;

  localparam int unsigned AXI_ADDR_W = 32;
  localparam int unsigned AXI_DATA_W = 64;
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;
  localparam logic [1:0]  RESP_OKAY  = 2'b00;

  // Master driven signals
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  rready;
  } axi_lite_req_t;

  // Slave driven signals
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic                  rvalid;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
  } axi_lite_resp_t;

  typedef struct packed {
    logic                  valid;  // One cycle per write
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } cfg_wr_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic                  done;   // R handshake
  } cfg_rd_t;

endpackage

//--- hw/axi_lite_slave.sv
// AXI4-Lite slave for the RAB configuration space
// Accepts AW and W independently, commits one write when both are in
// and serves one read at a time with data from the register side
module axi_lite_slave (
  input  logic                                Clk_CI,
  input  logic                                Rst_RBI,
  input  axi_lite_pkg::axi_lite_req_t         axi_req_i,
  output axi_lite_pkg::axi_lite_resp_t        axi_resp_o,
  output axi_lite_pkg::cfg_wr_t               cfg_wr_o,
  output axi_lite_pkg::cfg_rd_t               cfg_rd_o,
  input  logic [axi_lite_pkg::AXI_DATA_W-1:0] rdata_i
);
  import axi_lite_pkg::*;

  logic                  aw_done_q;
  logic                  w_done_q;
  logic                  b_run_q;   // Commit issued, B pending
  logic                  ar_done_q;
  logic [AXI_ADDR_W-1:0] aw_addr_q;
  logic [AXI_DATA_W-1:0] w_data_q;
  logic [AXI_STRB_W-1:0] w_strb_q;
  logic [AXI_ADDR_W-1:0] ar_addr_q;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic wr_both;

  // Ready is simply the channel not holding a transfer
  assign aw_hs   = axi_req_i.awvalid & ~aw_done_q;
  assign w_hs    = axi_req_i.wvalid & ~w_done_q;
  assign wr_both = aw_done_q & w_done_q;
  assign b_hs    = wr_both & axi_req_i.bready;
  assign ar_hs   = axi_req_i.arvalid & ~ar_done_q;
  assign r_hs    = ar_done_q & axi_req_i.rready;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      b_run_q   <= 1'b0;
      ar_done_q <= 1'b0;
    end
    else
    begin
      if (aw_hs)
        aw_done_q <= 1'b1;
      else if (b_hs)
        aw_done_q <= 1'b0;

      if (w_hs)
        w_done_q <= 1'b1;
      else if (b_hs)
        w_done_q <= 1'b0;

      b_run_q <= wr_both & ~b_hs;  // Edge detect for the commit

      if (ar_hs)
        ar_done_q <= 1'b1;
      else if (r_hs)
        ar_done_q <= 1'b0;
    end
  end

  // Captured payload
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      aw_addr_q <= axi_req_i.awaddr;
    if (w_hs)
    begin
      w_data_q <= axi_req_i.wdata;
      w_strb_q <= axi_req_i.wstrb;
    end
    if (ar_hs)
      ar_addr_q <= axi_req_i.araddr;
  end

  assign cfg_wr_o.valid = wr_both & ~b_run_q;
  assign cfg_wr_o.addr  = aw_addr_q;
  assign cfg_wr_o.data  = w_data_q;
  assign cfg_wr_o.strb  = w_strb_q;

  assign cfg_rd_o.addr  = ar_addr_q;
  assign cfg_rd_o.done  = r_hs;

  assign axi_resp_o.awready = ~aw_done_q;
  assign axi_resp_o.wready  = ~w_done_q;
  assign axi_resp_o.bvalid  = wr_both;
  assign axi_resp_o.bresp   = RESP_OKAY;
  assign axi_resp_o.arready = ~ar_done_q;
  assign axi_resp_o.rvalid  = ar_done_q;
  assign axi_resp_o.rdata   = rdata_i;
  assign axi_resp_o.rresp   = RESP_OKAY;

  // Responses are held until the master takes them
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_resp_o.bvalid && !axi_req_i.bready |=> axi_resp_o.bvalid)
    else $error("bvalid dropped before bready");

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_resp_o.rvalid && !axi_req_i.rready |=> axi_resp_o.rvalid)
    else $error("rvalid dropped before rready");

endmodule

//--- hw/l1_cfg_regfile.sv
// L1 slice register file
// Eight slices of four 64-bit words, each word masked to the field
// of its slot kind on write, with readback for the AXI read path
module l1_cfg_regfile (
  input  logic                                         Clk_CI,
  input  logic                                         Rst_RBI,
  input  axi_lite_pkg::cfg_wr_t                        cfg_wr_i,
  input  logic [axi_lite_pkg::AXI_ADDR_W-1:0]          rd_addr_i,
  output logic [axi_lite_pkg::AXI_DATA_W-1:0]          rd_word_o,
  output rab_cfg_pkg::l1_word_u [rab_cfg_pkg::N_REGS-1:0] l1_cfg_o
);
  import rab_cfg_pkg::*;
  import axi_lite_pkg::*;

  l1_word_u [N_REGS-1:0]  regs_q;
  reg_idx_t               wr_idx;
  reg_idx_t               rd_idx;
  logic                   wr_en;
  logic [AXI_DATA_W-1:0]  wr_merged;
  l1_word_u               wr_word;
  logic [AXI_DATA_W-1:0]  rd_full;

  assign wr_idx = cfg_wr_i.addr[ADDR_LSB +: REG_IDX_W];
  assign rd_idx = rd_addr_i[ADDR_LSB +: REG_IDX_W];
  assign wr_en  = cfg_wr_i.valid && (cfg_wr_i.addr < L1_AMAP_SIZE);

  // Byte merge, then keep only the field of the slot
  always_comb
  begin
    wr_merged = regs_q[wr_idx];
    for (int b = 0; b < AXI_STRB_W; b++)
    begin
      if (cfg_wr_i.strb[b])
        wr_merged[8*b +: 8] = cfg_wr_i.data[8*b +: 8];
    end

    wr_word = '0;
    case (slot_kind(wr_idx[1:0]))
      VIRT:    wr_word.virt.va   = wr_merged[ADDR_W_VIRT-1:0];
      PHYS:    wr_word.phys.pa   = wr_merged[ADDR_W_PHYS-1:0];
      default: wr_word.flags.val = wr_merged[N_FLAGS-1:0];
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      regs_q <= '0;
    else if (wr_en)
      regs_q[wr_idx] <= wr_word;
  end

  assign l1_cfg_o = regs_q;

  // Readback, upper half moved down for 32-bit debug access
  assign rd_full = regs_q[rd_idx];

  always_comb
  begin
    if (rd_addr_i >= L1_AMAP_SIZE)
      rd_word_o = '0;                   // Outside the L1 window
    else if (rd_addr_i[ADDR_LSB-1])
      rd_word_o = {{(AXI_DATA_W/2){1'b0}}, rd_full[AXI_DATA_W-1:AXI_DATA_W/2]};
    else
      rd_word_o = rd_full;
  end

  // Flag words hold nothing above the flag field
  for (genvar j = 3; j < N_REGS; j += 4)
  begin : g_flags_chk
    assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      regs_q[j].flags.rsvd == '0)
      else $error("flag word %0d has bits above the flag field", j);
  end

endmodule

//--- hw/miss_fifo.sv
// Miss entry FIFO
// Synchronous circular buffer with a count; pushes into a full
// buffer are dropped
module miss_fifo #(
  parameter int unsigned WIDTH = rab_cfg_pkg::ADDR_W_VIRT
) (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);
  import rab_cfg_pkg::*;

  logic [WIDTH-1:0]           mem_q [MISS_FIFO_DEPTH];
  logic [MISS_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [MISS_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [MISS_FIFO_PTR_W:0]   count_q;
  logic                       do_push;
  logic                       do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == MISS_FIFO_DEPTH);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];  // Head entry

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= (wr_ptr_q == MISS_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == MISS_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        count_q <= count_q + 1'b1;
      else if (do_pop && !do_push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= data_i;
  end

  // The handler only pops a FIFO it has seen non-empty
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    pop_i |-> !empty_o)
    else $error("pop from an empty miss FIFO");

endmodule

//--- hw/miss_handler.sv
// Miss handler
// Two FIFOs for miss addresses and miss IDs, filled by hardware misses
// or software writes and drained by reads of their windows
module miss_handler (
  input  logic                                  Clk_CI,
  input  logic                                  Rst_RBI,
  input  logic                                  miss_i,
  input  logic [rab_cfg_pkg::ADDR_W_VIRT-1:0]   miss_addr_i,
  input  logic [rab_cfg_pkg::MISS_ID_W-1:0]     miss_id_i,
  input  axi_lite_pkg::cfg_wr_t                 cfg_wr_i,
  input  axi_lite_pkg::cfg_rd_t                 cfg_rd_i,
  input  logic [axi_lite_pkg::AXI_DATA_W-1:0]   cfg_word_i,
  output logic [axi_lite_pkg::AXI_DATA_W-1:0]   rdata_o,
  output logic                                  mh_full_o
);
  import rab_cfg_pkg::*;
  import axi_lite_pkg::*;

  logic                   addr_push;
  logic [ADDR_W_VIRT-1:0] addr_din;
  logic                   addr_pop;
  logic [ADDR_W_VIRT-1:0] addr_dout;
  logic                   addr_empty;
  logic                   addr_full;
  logic                   id_push;
  logic [MISS_ID_W-1:0]   id_din;
  logic                   id_pop;
  logic [MISS_ID_W-1:0]   id_dout;
  logic                   id_empty;
  logic                   id_full;
  logic                   rd_addr_win;
  logic                   rd_id_win;

  // Hardware miss wins, a software push in the same cycle is lost
  assign addr_push = miss_i | (cfg_wr_i.valid && cfg_wr_i.addr == MH_ADDR_WIN);
  assign addr_din  = miss_i ? miss_addr_i : cfg_wr_i.data[ADDR_W_VIRT-1:0];
  assign id_push   = miss_i | (cfg_wr_i.valid && cfg_wr_i.addr == MH_ID_WIN);
  assign id_din    = miss_i ? miss_id_i : cfg_wr_i.data[MISS_ID_W-1:0];

  assign mh_full_o = (addr_push & addr_full) | (id_push & id_full);

  assign rd_addr_win = (cfg_rd_i.addr == MH_ADDR_WIN);
  assign rd_id_win   = (cfg_rd_i.addr == MH_ID_WIN);
  assign addr_pop    = cfg_rd_i.done & rd_addr_win & ~addr_empty;
  assign id_pop      = cfg_rd_i.done & rd_id_win & ~id_empty;

  always_comb
  begin
    rdata_o = cfg_word_i;              // L1 readback by default
    if (rd_addr_win)
    begin
      rdata_o                   = '0;
      rdata_o[AXI_DATA_W-1]     = addr_empty;
      rdata_o[ADDR_W_VIRT-1:0]  = addr_dout;
    end
    else if (rd_id_win)
    begin
      rdata_o                   = '0;
      rdata_o[AXI_DATA_W-1]     = id_empty;
      rdata_o[MISS_ID_W-1:0]    = id_dout;
    end
  end

  miss_fifo #(.WIDTH(ADDR_W_VIRT)) fifo_addr (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (addr_push),
    .data_i  (addr_din),
    .pop_i   (addr_pop),
    .data_o  (addr_dout),
    .empty_o (addr_empty),
    .full_o  (addr_full)
  );

  miss_fifo #(.WIDTH(MISS_ID_W)) fifo_id (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (id_push),
    .data_i  (id_din),
    .pop_i   (id_pop),
    .data_o  (id_dout),
    .empty_o (id_empty),
    .full_o  (id_full)
  );

endmodule

//--- hw/rab_cfg_pkg.sv
// RAB configuration constants
// Register map of the L1 slice file, miss FIFO sizes and the word
// layout shared by the register file and its users
package rab_cfg_pkg;

  localparam int unsigned N_REGS          = 32;
  localparam int unsigned ADDR_LSB        = 3;     // 64-bit registers
  localparam int unsigned REG_IDX_W       = 5;
  localparam int unsigned L1_AMAP_SIZE    = 'h100;
  localparam int unsigned ADDR_W_VIRT     = 32;
  localparam int unsigned ADDR_W_PHYS     = 40;
  localparam int unsigned N_FLAGS         = 4;
  localparam int unsigned MISS_ID_W       = 10;
  localparam int unsigned MISS_FIFO_DEPTH = 16;
  localparam int unsigned MISS_FIFO_PTR_W = $clog2(MISS_FIFO_DEPTH);
  localparam int unsigned MH_ADDR_WIN     = 'h0;   // Miss address FIFO
  localparam int unsigned MH_ID_WIN       = 'h8;   // Miss ID FIFO

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Word kind within a slice, low two index bits
  typedef enum logic [1:0] {
    VIRT  = 2'b00,
    PHYS  = 2'b10,
    FLAGS = 2'b11
  } slot_kind_e;

  // One slice word, decoded by the kind of its slot
  typedef union packed {
    struct packed {
      logic [63-ADDR_W_VIRT:0] rsvd;
      logic [ADDR_W_VIRT-1:0]  va;
    } virt;
    struct packed {
      logic [63-ADDR_W_PHYS:0] rsvd;
      logic [ADDR_W_PHYS-1:0]  pa;
    } phys;
    struct packed {
      logic [63-N_FLAGS:0]     rsvd;
      logic [N_FLAGS-1:0]      val;
    } flags;
  } l1_word_u;

  // Indices 0 and 1 both hold the virtual address
  function automatic slot_kind_e slot_kind(input logic [1:0] idx_lo);
    if (!idx_lo[1])
      return VIRT;
    else if (!idx_lo[0])
      return PHYS;
    else
      return FLAGS;
  endfunction

endpackage

//--- hw/rab_cfg_top.sv
// RAB configuration block
// AXI4-Lite slave in front of the L1 slice registers and the miss
// handler, which also selects the final read data
module rab_cfg_top (
  input  logic                                         Clk_CI,
  input  logic                                         Rst_RBI,
  input  axi_lite_pkg::axi_lite_req_t                  axi_req_i,
  output axi_lite_pkg::axi_lite_resp_t                 axi_resp_o,
  input  logic                                         miss_i,
  input  logic [rab_cfg_pkg::ADDR_W_VIRT-1:0]          miss_addr_i,
  input  logic [rab_cfg_pkg::MISS_ID_W-1:0]            miss_id_i,
  output logic                                         mh_full_o,
  output rab_cfg_pkg::l1_word_u [rab_cfg_pkg::N_REGS-1:0] l1_cfg_o
);
  import axi_lite_pkg::*;

  cfg_wr_t               cfg_wr;
  cfg_rd_t               cfg_rd;
  logic [AXI_DATA_W-1:0] l1_rd_word;
  logic [AXI_DATA_W-1:0] rdata;   // After the FIFO window mux

  axi_lite_slave i_axi_lite_slave (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .axi_req_i  (axi_req_i),
    .axi_resp_o (axi_resp_o),
    .cfg_wr_o   (cfg_wr),
    .cfg_rd_o   (cfg_rd),
    .rdata_i    (rdata)
  );

  l1_cfg_regfile i_l1_cfg_regfile (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .cfg_wr_i  (cfg_wr),
    .rd_addr_i (cfg_rd.addr),
    .rd_word_o (l1_rd_word),
    .l1_cfg_o  (l1_cfg_o)
  );

  miss_handler i_miss_handler (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .miss_i      (miss_i),
    .miss_addr_i (miss_addr_i),
    .miss_id_i   (miss_id_i),
    .cfg_wr_i    (cfg_wr),
    .cfg_rd_i    (cfg_rd),
    .cfg_word_i  (l1_rd_word),
    .rdata_o     (rdata),
    .mh_full_o   (mh_full_o)
  );

endmodule

//--- list.f
+incdir+verif
hw/rab_cfg_pkg.sv
hw/axi_lite_pkg.sv
hw/axi_lite_slave.sv
hw/l1_cfg_regfile.sv
hw/miss_fifo.sv
hw/miss_handler.sv
hw/rab_cfg_top.sv
verif/tb_rab_cfg.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RAB configuration testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_rab_cfg --Mdir obj_dir -o sim_rab_cfg
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_rab_cfg)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

//--- verif/tb_axi_lite_bus.svh
// AXI4-Lite bus helpers for the RAB configuration testbench
// Write and read tasks with a timeout on every wait, the random
// number source and the field masks of the slice words
`ifndef TB_AXI_LITE_BUS_SVH
`define TB_AXI_LITE_BUS_SVH

localparam int unsigned WAIT_CYCLES = 50;

logic [63:0] rng_q = 64'd72151;

function automatic logic [63:0] xorshift();
  rng_q = rng_q ^ (rng_q << 13);
  rng_q = rng_q ^ (rng_q >> 7);
  rng_q = rng_q ^ (rng_q << 17);
  return rng_q;
endfunction

// VA in words 0 and 1, PA in word 2, flags in word 3
function automatic logic [63:0] field_mask(input int unsigned idx);
  case (idx % 4)
    0, 1:    return 64'h0000_0000_FFFF_FFFF;
    2:       return 64'h0000_00FF_FFFF_FFFF;
    default: return 64'h0000_0000_0000_000F;
  endcase
endfunction

function automatic logic [63:0] strobe_merge(input logic [63:0] old_word,
                                             input logic [63:0] data,
                                             input logic [7:0]  strb);
  logic [63:0] word;
  word = old_word;
  for (int b = 0; b < 8; b++)
  begin
    if (strb[b])
      word[8*b +: 8] = data[8*b +: 8];
  end
  return word;
endfunction

// AW and W together, each valid dropped after its own handshake
task automatic put_write(input logic [31:0] addr, input logic [63:0] data,
                         input logic [7:0] strb);
  int unsigned waited;
  logic        aw_go;
  logic        w_go;
  waited          = 0;
  axi_req.awaddr  = addr;
  axi_req.wdata   = data;
  axi_req.wstrb   = strb;
  axi_req.awvalid = 1'b1;
  axi_req.wvalid  = 1'b1;
  while (axi_req.awvalid || axi_req.wvalid)
  begin
    aw_go = axi_req.awvalid && axi_resp.awready;
    w_go  = axi_req.wvalid && axi_resp.wready;
    @(negedge Clk_CI);
    if (aw_go)
      axi_req.awvalid = 1'b0;
    if (w_go)
      axi_req.wvalid = 1'b0;
    waited++;
    if (waited > WAIT_CYCLES)
      abort("AW/W handshake");
  end
endtask

task automatic take_b(input int unsigned hold);
  int unsigned waited;
  waited = 0;
  repeat (hold) @(negedge Clk_CI);   // bready held low
  axi_req.bready = 1'b1;
  while (!axi_resp.bvalid)
  begin
    @(negedge Clk_CI);
    waited++;
    if (waited > WAIT_CYCLES)
      abort("B response");
  end
  @(negedge Clk_CI);
  axi_req.bready = 1'b0;
endtask

// Expected word is checked by assertion on the R handshake
task automatic read_check(input logic [31:0] addr, input logic [63:0] exp_word,
                          input logic [63:0] mask);
  int unsigned waited;
  waited          = 0;
  cur_addr        = addr;
  exp_rdata       = exp_word & mask;
  exp_mask        = mask;
  chk_en          = 1'b1;
  axi_req.araddr  = addr;
  axi_req.arvalid = 1'b1;
  while (!axi_resp.arready)
  begin
    @(negedge Clk_CI);
    waited++;
    if (waited > WAIT_CYCLES)
      abort("AR handshake");
  end
  @(negedge Clk_CI);
  axi_req.arvalid = 1'b0;
  axi_req.rready  = 1'b1;
  waited          = 0;
  while (!axi_resp.rvalid)
  begin
    @(negedge Clk_CI);
    waited++;
    if (waited > WAIT_CYCLES)
      abort("R response");
  end
  @(negedge Clk_CI);
  axi_req.rready = 1'b0;
  chk_en         = 1'b0;
endtask

`endif

//--- verif/tb_rab_cfg.sv
// Testbench for the RAB configuration block
// AXI4-Lite accesses and miss pushes checked by assertions against a
// reference model of the slice registers and miss FIFOs
module tb_rab_cfg;
  import rab_cfg_pkg::*;
  import axi_lite_pkg::*;

  logic                  Clk_CI;
  logic                  Rst_RBI;
  axi_lite_req_t         axi_req;
  axi_lite_resp_t        axi_resp;
  logic                  miss_i;
  logic [31:0]           miss_addr;
  logic [9:0]            miss_id;
  logic                  mh_full;
  l1_word_u [N_REGS-1:0] l1_cfg;

  logic [63:0] ref_regs [32];   // Reference slice registers
  logic [31:0] ref_addr_q [$];
  logic [9:0]  ref_id_q [$];
  logic        chk_en;
  logic [31:0] cur_addr;
  logic [63:0] exp_rdata;
  logic [63:0] exp_mask;
  logic        full_ok;         // Full event allowed now
  int unsigned full_seen;
  int unsigned errors;
  int unsigned tests_failed;

  `include "tb_axi_lite_bus.svh"

  rab_cfg_top UUT (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .axi_req_i   (axi_req),
    .axi_resp_o  (axi_resp),
    .miss_i      (miss_i),
    .miss_addr_i (miss_addr),
    .miss_id_i   (miss_id),
    .mh_full_o   (mh_full),
    .l1_cfg_o    (l1_cfg)
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever #50 Clk_CI = ~Clk_CI;
  end

  always @(posedge Clk_CI)
  begin
    if (mh_full)
      full_seen++;
  end

  function automatic void report_fail(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endfunction

  task automatic abort(input string what);
    $display("Timeout: no %s within %0d cycles at time %0t", what, WAIT_CYCLES, $time);
    $display("Some tests failed");
    $finish;
  endtask

  a_reset_state: assert property (@(posedge Clk_CI) $rose(Rst_RBI) |->
    axi_resp.awready && axi_resp.wready && axi_resp.arready &&
    !axi_resp.bvalid && !axi_resp.rvalid && !mh_full)
    else report_fail("ready or valid wrong after reset");

  a_rdata: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_resp.rvalid && axi_req.rready && chk_en |->
      (axi_resp.rdata & exp_mask) == exp_rdata && axi_resp.rresp == 2'b00)
    else report_fail($sformatf("read of %h returned %h resp %0d, expected %h OKAY",
                               cur_addr, $sampled(axi_resp.rdata),
                               $sampled(axi_resp.rresp), exp_rdata));

  a_b_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_resp.bvalid && !axi_req.bready |=> axi_resp.bvalid)
    else report_fail("bvalid dropped before bready");

  a_b_blocks: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_resp.bvalid |-> !axi_resp.awready && !axi_resp.wready && axi_resp.bresp == 2'b00)
    else report_fail("new write accepted or bad bresp while B pending");

  a_full: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) mh_full |-> full_ok)
    else report_fail("mh_full_o raised without a push into a full FIFO");

  // Every slice word on l1_cfg_o against the reference registers
  function automatic void compare_l1_cfg();
    for (int i = 0; i < 32; i++)
    begin
      assert (l1_cfg[i] == ref_regs[i])
        else report_fail($sformatf("l1_cfg_o[%0d] is %h, expected %h", i, l1_cfg[i],
                                   ref_regs[i]));
    end
  endfunction

  // Window reads pop the model and empty windows only check bit 63
  task automatic read_model(input logic [31:0] addr);
    logic [63:0] word;
    logic [63:0] mask;
    mask = '1;
    if (addr == 32'h0 && ref_addr_q.size() == 0)
      word = 64'h8000_0000_0000_0000;
    else if (addr == 32'h0)
      word = {32'h0, ref_addr_q.pop_front()};
    else if (addr == 32'h8 && ref_id_q.size() == 0)
      word = 64'h8000_0000_0000_0000;
    else if (addr == 32'h8)
      word = {54'h0, ref_id_q.pop_front()};
    else if (addr >= 32'h100)
      word = '0;
    else if (addr[2])
      word = {32'h0, ref_regs[addr[7:3]][63:32]};   // Upper half for 32-bit access
    else
      word = ref_regs[addr[7:3]];
    if (word[63])
      mask = word;
    read_check(addr, word, mask);
  endtask

  task automatic sw_write(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb, input int unsigned hold);
    if (addr < 32'h100)
      ref_regs[addr[7:3]] = strobe_merge(ref_regs[addr[7:3]], data, strb) & field_mask(addr[7:3]);
    if (addr == 32'h0 && ref_addr_q.size() < 16)
      ref_addr_q.push_back(data[31:0]);
    if (addr == 32'h8 && ref_id_q.size() < 16)
      ref_id_q.push_back(data[9:0]);
    put_write(addr, data, strb);
    take_b(hold);
  endtask

  task automatic hw_miss(input logic [31:0] addr, input logic [9:0] id);
    miss_addr = addr;
    miss_id   = id;
    miss_i    = 1'b1;
    if (ref_addr_q.size() < 16)
      ref_addr_q.push_back(addr);
    if (ref_id_q.size() < 16)
      ref_id_q.push_back(id);
    @(negedge Clk_CI);
    miss_i = 1'b0;
  endtask

  task automatic end_test(input int unsigned num, input string name, input int unsigned base);
    if (errors == base)
      $display("Test %0d %s: passed", num, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", num, name, errors - base);
    end
  endtask

  initial
  begin
    logic [63:0] data;
    int unsigned idx;
    int unsigned base;
    axi_req   = '0;
    miss_i    = 1'b0;
    miss_addr = '0;
    miss_id   = '0;
    chk_en    = 1'b0;
    cur_addr  = '0;
    exp_rdata = '0;
    exp_mask  = '0;
    full_ok   = 1'b0;
    full_seen = 0;
    errors    = 0;
    tests_failed = 0;
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    Rst_RBI = 1'b0;
    repeat (16) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);

    base = errors;
    for (int i = 0; i < 32; i++)
      read_model(i * 8);                 // Words 0 and 1 sit behind the FIFO windows
    compare_l1_cfg();
    end_test(1, "reset state", base);

    base = errors;
    for (int k = 0; k < 4; k++)
    begin
      idx  = 4 * (1 + int'(xorshift() % 64'd7)) + k;
      data = xorshift();
      sw_write(idx * 8, data, data[7:0] ^ data[47:40], 0);
      read_model(idx * 8);
      read_model(idx * 8 + 4);
    end
    compare_l1_cfg();
    end_test(2, "slot masking and readback", base);

    base = errors;
    data = xorshift();
    put_write(32'h100 | {24'h0, data[7:3], 3'b000}, xorshift(), 8'hFF);
    axi_req.awaddr  = 32'h1F8;           // Second write offered while B is pending
    axi_req.wdata   = data;
    axi_req.awvalid = 1'b1;
    axi_req.wvalid  = 1'b1;
    take_b(6);                           // Hold bready low for a while
    put_write(32'h1F8, data, 8'hFF);     // Accepted only after the B handshake
    take_b(0);
    for (int i = 2; i < 32; i++)
      read_model(i * 8);
    read_model(32'h108);
    compare_l1_cfg();
    end_test(3, "write outside window and B back-pressure", base);

    base = errors;
    for (int i = 0; i < 5; i++)
    begin
      data = xorshift();
      hw_miss(data[31:0], data[41:32]);
    end
    for (int i = 0; i < 6; i++)
      read_model(32'h0);
    for (int i = 0; i < 6; i++)
      read_model(32'h8);
    end_test(4, "miss order and empty flag", base);

    base = errors;
    for (int i = 0; i < 16; i++)
      sw_write(32'h0, xorshift(), 8'hFF, 0);
    full_seen = 0;
    full_ok   = 1'b1;
    sw_write(32'h0, xorshift(), 8'hFF, 0);   // 17th push is dropped
    full_ok   = 1'b0;
    a_full_once: assert (full_seen == 1)
      else report_fail($sformatf("mh_full_o seen %0d cycles, expected 1", full_seen));
    for (int i = 0; i < 17; i++)
      read_model(32'h0);
    for (int i = 0; i < 2; i++)
      sw_write(32'h8, xorshift(), 8'hFF, 0);
    data        = xorshift();
    ref_regs[1] = data & field_mask(1);
    put_write(32'h8, data, 8'hFF);
    data = xorshift();
    hw_miss(data[31:0], data[41:32]);    // Lands with the commit pulse
    take_b(0);
    for (int i = 0; i < 4; i++)
      read_model(32'h8);
    for (int i = 0; i < 2; i++)
      read_model(32'h0);
    compare_l1_cfg();
    end_test(5, "software push, full and miss priority", base);

    $display("5 tests run, %0d failed, %0d check errors", tests_failed, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
